/* source/icache_mem_pkg.sv */
package icache_mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Memory side of the cache
    ////////////////////////////////////////////////////////////////////////////

    // Physical byte address
    localparam int ADDR_WIDTH = 32;

    // One cache line, returned whole by memory
    localparam int LINE_WIDTH = 128;

endpackage

/* source/icache_geom_pkg.sv */
package icache_geom_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int NSET            = 256;
    localparam int NWAY            = 2;
    localparam int OFFSET_WIDTH    = 4;
    localparam int INDEX_WIDTH     = 8;
    localparam int TAG_WIDTH       = 20;
    // Valid bit on top of the tag
    localparam int TAG_ENTRY_WIDTH = TAG_WIDTH + 1;

    // One address word, seen flat or split into its fields
    typedef union packed {
        logic [TAG_WIDTH+INDEX_WIDTH+OFFSET_WIDTH-1:0] word;
        struct packed {
            logic [TAG_WIDTH-1:0]    tag;
            logic [INDEX_WIDTH-1:0]  index;
            logic [OFFSET_WIDTH-1:0] offset;
        } f;
    } icache_addr_u;

endpackage

/* source/icache_refill_if.sv */
`timescale 1ns/1ps

interface icache_refill_if;

    // Miss requests from the lookup
    logic                                    miss_1;
    logic                                    miss_2;
    logic [icache_mem_pkg::ADDR_WIDTH-1:0]   miss_addr_1;
    logic [icache_mem_pkg::ADDR_WIDTH-1:0]   miss_addr_2;

    // Fill writes from the refill engine
    logic                                    fill_we;
    logic                                    fill_port;
    logic [$clog2(icache_geom_pkg::NWAY)-1:0] fill_way;
    logic [icache_geom_pkg::TAG_WIDTH-1:0]   fill_tag;
    logic [icache_geom_pkg::INDEX_WIDTH-1:0] fill_index;
    logic [icache_mem_pkg::LINE_WIDTH-1:0]   fill_line;
    // One bit per port, bit 0 is port 1
    logic [1:0]                              busy_port;

    modport lookup (
        output miss_1, miss_2, miss_addr_1, miss_addr_2,
        input  fill_we, fill_port, fill_way, fill_tag, fill_index, fill_line, busy_port
    );

    modport refill (
        input  miss_1, miss_2, miss_addr_1, miss_addr_2,
        output fill_we, fill_port, fill_way, fill_tag, fill_index, fill_line, busy_port
    );

endinterface

/* source/icache_way_ram.sv */
`timescale 1ns/1ps

module icache_way_ram #(
    parameter int WIDTH = icache_geom_pkg::TAG_ENTRY_WIDTH
) (
    input  logic                                    clk,
    input  logic                                    we_a_i,
    input  logic                                    we_b_i,
    input  logic [icache_geom_pkg::INDEX_WIDTH-1:0] addr_a_i,
    input  logic [icache_geom_pkg::INDEX_WIDTH-1:0] addr_b_i,
    input  logic [WIDTH-1:0]                        wdata_a_i,
    input  logic [WIDTH-1:0]                        wdata_b_i,
    output logic [WIDTH-1:0]                        rdata_a_o,
    output logic [WIDTH-1:0]                        rdata_b_o
);

    // Starts cleared so every valid bit reads zero
    logic [WIDTH-1:0] mem [icache_geom_pkg::NSET] = '{default: '0};

    // Read-first on both sides
    always_ff @(posedge clk) begin
        if (we_a_i) begin
            mem[addr_a_i] <= wdata_a_i;
        end
        if (we_b_i) begin
            mem[addr_b_i] <= wdata_b_i;
        end
        rdata_a_o <= mem[addr_a_i];
        rdata_b_o <= mem[addr_b_i];
    end

    // Only one side fills at a time, so a collision means broken steering
    assert property (@(posedge clk) !(we_a_i && we_b_i && addr_a_i == addr_b_i))
    else $error("both RAM sides write set %0d", addr_a_i);

endmodule

/* source/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  rreq_1_i,
    input  logic                                  rreq_2_i,
    input  logic [icache_mem_pkg::ADDR_WIDTH-1:0] raddr_1_i,
    input  logic [icache_mem_pkg::ADDR_WIDTH-1:0] raddr_2_i,
    output logic                                  rvalid_1_o,
    output logic                                  rvalid_2_o,
    output logic [icache_mem_pkg::LINE_WIDTH-1:0] rdata_1_o,
    output logic [icache_mem_pkg::LINE_WIDTH-1:0] rdata_2_o,
    icache_refill_if.lookup                       refill
);

    localparam int NWAY = icache_geom_pkg::NWAY;

    logic [1:0]                                    rreq;
    icache_geom_pkg::icache_addr_u [1:0]           raddr;
    logic [1:0]                                    req_q;
    icache_geom_pkg::icache_addr_u [1:0]           addr_q;
    logic [1:0]                                    accept;
    logic [1:0]                                    waiting;
    logic [1:0]                                    hit;
    logic [1:0]                                    rvalid;
    logic [1:0][icache_mem_pkg::LINE_WIDTH-1:0]    rdata;

    logic [1:0]                                    fill_on_side;
    logic [1:0]                                    fill_side_q;
    logic [1:0]                                    fill_pend_q;
    logic [icache_mem_pkg::LINE_WIDTH-1:0]         fill_line_q;

    logic [1:0][icache_geom_pkg::INDEX_WIDTH-1:0]  side_index;
    logic [NWAY-1:0][1:0]                          ram_we;
    logic [NWAY-1:0][1:0]                          way_hit;
    logic [NWAY-1:0][1:0][icache_geom_pkg::TAG_ENTRY_WIDTH-1:0] tag_rd;
    logic [NWAY-1:0][1:0][icache_mem_pkg::LINE_WIDTH-1:0]       data_rd;

    assign rreq  = {rreq_2_i, rreq_1_i};
    assign raddr = {raddr_2_i, raddr_1_i};

    ////////////////////////////////////////////////////////////////////////////
    // Request registers and RAM addressing
    ////////////////////////////////////////////////////////////////////////////

    assign accept  = rvalid | ~req_q;
    assign waiting = req_q & ~rvalid;

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (rst) begin
                req_q[p] <= 1'b0;
            end else if (accept[p]) begin
                req_q[p] <= rreq[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (accept[p]) begin
                addr_q[p] <= raddr[p];
            end
        end
    end

    assign fill_on_side[0] = refill.fill_we & ~refill.fill_port;
    assign fill_on_side[1] = refill.fill_we & refill.fill_port;

    // A fill takes over its side, otherwise keep re-reading the held set
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (fill_on_side[p]) begin
                side_index[p] = refill.fill_index;
            end else if (waiting[p]) begin
                side_index[p] = addr_q[p].f.index;
            end else begin
                side_index[p] = raddr[p].f.index;
            end
            for (int w = 0; w < NWAY; w++) begin
                ram_we[w][p] = fill_on_side[p] && (int'(refill.fill_way) == w);
            end
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        icache_way_ram #(
            .WIDTH(icache_geom_pkg::TAG_ENTRY_WIDTH)
        ) u_tag_ram (
            .clk      (clk),
            .we_a_i   (ram_we[w][0]),
            .we_b_i   (ram_we[w][1]),
            .addr_a_i (side_index[0]),
            .addr_b_i (side_index[1]),
            .wdata_a_i({1'b1, refill.fill_tag}),
            .wdata_b_i({1'b1, refill.fill_tag}),
            .rdata_a_o(tag_rd[w][0]),
            .rdata_b_o(tag_rd[w][1])
        );

        icache_way_ram #(
            .WIDTH(icache_mem_pkg::LINE_WIDTH)
        ) u_data_ram (
            .clk      (clk),
            .we_a_i   (ram_we[w][0]),
            .we_b_i   (ram_we[w][1]),
            .addr_a_i (side_index[0]),
            .addr_b_i (side_index[1]),
            .wdata_a_i(refill.fill_line),
            .wdata_b_i(refill.fill_line),
            .rdata_a_o(data_rd[w][0]),
            .rdata_b_o(data_rd[w][1])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag compare and fill bypass
    ////////////////////////////////////////////////////////////////////////////

    // Line just filled for the held address is returned straight away
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (rst) begin
                fill_side_q[p] <= 1'b0;
                fill_pend_q[p] <= 1'b0;
            end else begin
                fill_side_q[p] <= fill_on_side[p];
                fill_pend_q[p] <= fill_on_side[p] && waiting[p]
                                  && addr_q[p].f.tag == refill.fill_tag
                                  && addr_q[p].f.index == refill.fill_index;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill.fill_we) begin
            fill_line_q <= refill.fill_line;
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            hit[p]   = fill_pend_q[p];
            rdata[p] = fill_line_q;
            for (int w = 0; w < NWAY; w++) begin
                way_hit[w][p] = tag_rd[w][p][icache_geom_pkg::TAG_WIDTH]
                    && tag_rd[w][p][icache_geom_pkg::TAG_WIDTH-1:0] == addr_q[p].f.tag;
                // RAM output is for the fill set when a fill used this side
                if (!fill_pend_q[p] && !fill_side_q[p] && way_hit[w][p]) begin
                    hit[p]   = 1'b1;
                    rdata[p] = data_rd[w][p];
                end
            end
        end
    end

    assign rvalid = req_q & hit;

    assign rvalid_1_o = rvalid[0];
    assign rvalid_2_o = rvalid[1];
    assign rdata_1_o  = rdata[0];
    assign rdata_2_o  = rdata[1];

    assign refill.miss_1      = req_q[0] & ~hit[0] & ~refill.busy_port[0] & ~fill_side_q[0];
    assign refill.miss_2      = req_q[1] & ~hit[1] & ~refill.busy_port[1] & ~fill_side_q[1];
    assign refill.miss_addr_1 = addr_q[0].word;
    assign refill.miss_addr_2 = addr_q[1].word;

    // Requester holds rreq until rvalid, so it was there a cycle before
    for (genvar p = 0; p < 2; p++) begin : g_chk
        assert property (@(posedge clk) disable iff (rst) rvalid[p] |-> $past(rreq[p]))
        else $error("rvalid on port %0d without a held request", p + 1);
    end

endmodule

/* source/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill (
    input  logic                                  clk,
    input  logic                                  rst,
    icache_refill_if.refill                       refill,
    output logic                                  mem_req_o,
    output logic [icache_mem_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    input  logic                                  mem_ready_i,
    input  logic                                  mem_rvalid_i,
    input  logic [icache_mem_pkg::LINE_WIDTH-1:0] mem_line_i
);

    enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } state_q, state_d;

    // Served port, 0 is port 1
    logic                                  port_q;
    icache_geom_pkg::icache_addr_u         line_q;
    logic                                  capture;
    logic                                  capture_port;
    icache_geom_pkg::icache_addr_u         capture_line;
    logic [2:0]                            lfsr_q;

    ////////////////////////////////////////////////////////////////////////////
    // Refill FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d      = state_q;
        capture      = 1'b0;
        capture_port = 1'b0;
        case (state_q)
            IDLE: begin
                if (refill.miss_1) begin
                    state_d = REQ;
                    capture = 1'b1;
                end else if (refill.miss_2) begin
                    state_d      = REQ;
                    capture      = 1'b1;
                    capture_port = 1'b1;
                end
            end
            REQ: begin
                if (mem_ready_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (mem_rvalid_i) begin
                    // Port 2 next if it was left waiting behind port 1
                    if (!port_q && refill.miss_2) begin
                        state_d      = REQ;
                        capture      = 1'b1;
                        capture_port = 1'b1;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Line-aligned copy of the miss address
    always_comb begin
        capture_line          = capture_port ? refill.miss_addr_2 : refill.miss_addr_1;
        capture_line.f.offset = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            port_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                port_q <= capture_port;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            line_q <= capture_line;
        end
    end

    // x^3 + x^2 + 1, runs every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 3'b001;
        end else begin
            lfsr_q <= {lfsr_q[1:0], lfsr_q[2] ^ lfsr_q[1]};
        end
    end

    assign mem_req_o  = state_q == REQ;
    assign mem_addr_o = line_q.word;

    assign refill.busy_port[0] = state_q != IDLE && !port_q;
    assign refill.busy_port[1] = state_q != IDLE && port_q;

    assign refill.fill_we    = state_q == WAIT && mem_rvalid_i;
    assign refill.fill_port  = port_q;
    assign refill.fill_way   = lfsr_q[$clog2(icache_geom_pkg::NWAY)-1:0];
    assign refill.fill_tag   = line_q.f.tag;
    assign refill.fill_index = line_q.f.index;
    assign refill.fill_line  = mem_line_i;

    ////////////////////////////////////////////////////////////////////////////
    // Memory protocol checks
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o))
    else $error("memory request dropped or changed before acceptance");

    assert property (@(posedge clk) disable iff (rst) mem_rvalid_i |-> state_q == WAIT)
    else $error("memory response with no refill outstanding");

endmodule

/* source/icache_top.sv */
`timescale 1ns/1ps

module icache_top (
    input  logic                                  clk,
    input  logic                                  rst,

    // Read port 1
    input  logic                                  rreq_1_i,
    input  logic [icache_mem_pkg::ADDR_WIDTH-1:0] raddr_1_i,
    output logic                                  rvalid_1_o,
    output logic [icache_mem_pkg::LINE_WIDTH-1:0] rdata_1_o,

    // Read port 2
    input  logic                                  rreq_2_i,
    input  logic [icache_mem_pkg::ADDR_WIDTH-1:0] raddr_2_i,
    output logic                                  rvalid_2_o,
    output logic [icache_mem_pkg::LINE_WIDTH-1:0] rdata_2_o,

    // Memory
    output logic                                  mem_req_o,
    output logic [icache_mem_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    input  logic                                  mem_ready_i,
    input  logic                                  mem_rvalid_i,
    input  logic [icache_mem_pkg::LINE_WIDTH-1:0] mem_line_i
);

    icache_refill_if u_refill_if ();

    icache_lookup u_lookup (
        .clk       (clk),
        .rst       (rst),
        .rreq_1_i  (rreq_1_i),
        .rreq_2_i  (rreq_2_i),
        .raddr_1_i (raddr_1_i),
        .raddr_2_i (raddr_2_i),
        .rvalid_1_o(rvalid_1_o),
        .rvalid_2_o(rvalid_2_o),
        .rdata_1_o (rdata_1_o),
        .rdata_2_o (rdata_2_o),
        .refill    (u_refill_if.lookup)
    );

    icache_refill u_refill (
        .clk         (clk),
        .rst         (rst),
        .refill      (u_refill_if.refill),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_ready_i (mem_ready_i),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_line_i  (mem_line_i)
    );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

/* verification/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STREAM_LEN     = 200;
    localparam int AW             = icache_mem_pkg::ADDR_WIDTH;
    localparam int LW             = icache_mem_pkg::LINE_WIDTH;

    logic          clk;
    logic          rst;
    logic [1:0]    rreq          = '0;
    logic [AW-1:0] raddr [2]     = '{default: '0};
    wire  [1:0]    rvalid;
    wire  [LW-1:0] rdata_1;
    wire  [LW-1:0] rdata_2;
    wire           mem_req;
    wire  [AW-1:0] mem_addr;
    logic          mem_ready     = 1'b0;
    logic          mem_rvalid    = 1'b0;
    logic [LW-1:0] mem_line      = '0;

    integer        seed          = 32'h7e674027;
    logic [AW-1:0] exp_addr [2]  = '{default: '0};
    logic [1:0]    hit_probe     = '0;
    logic          req_seen      = 1'b0;
    logic          req_probe     = 1'b0;
    logic          order_probe   = 1'b0;
    int            exp_req_count = 0;
    logic [AW-1:0] exp_first     = '0;
    logic [AW-1:0] exp_second    = '0;
    int            req_count     = 0;
    logic [AW-1:0] prev_req_addr = '0;
    logic [AW-1:0] last_req_addr = '0;
    int            fixed_delay   = -1;
    int            ready_wait    = -1;
    int            resp_wait     = 0;
    logic          resp_pending  = 1'b0;
    logic [AW-1:0] resp_addr     = '0;
    logic [AW-1:0] stream [2][STREAM_LEN];
    int            errors        = 0;
    int            tests         = 0;

    tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(2)) u_clock (.clk_o(clk), .rst_o(rst));

    icache_top dut (
        .clk         (clk),
        .rst         (rst),
        .rreq_1_i    (rreq[0]),
        .raddr_1_i   (raddr[0]),
        .rvalid_1_o  (rvalid[0]),
        .rdata_1_o   (rdata_1),
        .rreq_2_i    (rreq[1]),
        .raddr_2_i   (raddr[1]),
        .rvalid_2_o  (rvalid[1]),
        .rdata_2_o   (rdata_2),
        .mem_req_o   (mem_req),
        .mem_addr_o  (mem_addr),
        .mem_ready_i (mem_ready),
        .mem_rvalid_i(mem_rvalid),
        .mem_line_i  (mem_line)
    );

    // Line at A holds the words A, A+4, A+8 and A+12 from the low end up
    function automatic logic [LW-1:0] model_line(input logic [AW-1:0] addr);
        logic [AW-1:0] base;
        base = {addr[AW-1:4], 4'b0000};
        return {base + 32'd12, base + 32'd8, base + 32'd4, base};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        mem_ready  = 1'b0;
        if (resp_pending) begin
            resp_wait = resp_wait - 1;
            if (resp_wait == 0) begin
                mem_rvalid   = 1'b1;
                mem_line     = model_line(resp_addr);
                resp_pending = 1'b0;
            end
        end
        if (mem_req && !resp_pending) begin
            if (ready_wait < 0) begin
                ready_wait = (fixed_delay >= 0) ? fixed_delay : int'($unsigned($random(seed)) % 4);
            end
            if (ready_wait == 0) begin
                mem_ready    = 1'b1;
                resp_addr    = mem_addr;
                resp_wait    = 1 + int'($unsigned($random(seed)) % 4);
                resp_pending = 1'b1;
                ready_wait   = -1;
            end else begin
                ready_wait = ready_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && mem_req && mem_ready) begin
            req_count     <= req_count + 1;
            prev_req_addr <= last_req_addr;
            last_req_addr <= mem_addr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk) disable iff (rst)
        !req_seen |-> !rvalid[0] && !rvalid[1] && !mem_req)
    else begin
        errors++;
        $display("FAIL %0t: output active before any request", $time);
    end

    a_data_1: assert property (@(posedge clk) disable iff (rst)
        rvalid[0] |-> rdata_1 == model_line(exp_addr[0]))
    else begin
        errors++;
        $display("FAIL %0t: port 1 line for %08h wrong", $time, exp_addr[0]);
    end

    a_data_2: assert property (@(posedge clk) disable iff (rst)
        rvalid[1] |-> rdata_2 == model_line(exp_addr[1]))
    else begin
        errors++;
        $display("FAIL %0t: port 2 line for %08h wrong", $time, exp_addr[1]);
    end

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem_addr[3:0] == 4'h0)
    else begin
        errors++;
        $display("FAIL %0t: memory address %08h not aligned", $time, mem_addr);
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr))
    else begin
        errors++;
        $display("FAIL %0t: memory request changed while stalled", $time);
    end

    a_hit_1: assert property (@(posedge clk) disable iff (rst)
        hit_probe[0] |=> rvalid[0] && !mem_req)
    else begin
        errors++;
        $display("FAIL %0t: port 1 hit not answered next cycle", $time);
    end

    a_hit_2: assert property (@(posedge clk) disable iff (rst)
        hit_probe[1] |=> rvalid[1] && !mem_req)
    else begin
        errors++;
        $display("FAIL %0t: port 2 hit not answered next cycle", $time);
    end

    a_req_count: assert property (@(posedge clk) disable iff (rst)
        req_probe |-> req_count == exp_req_count)
    else begin
        errors++;
        $display("FAIL %0t: %0d memory requests", $time, req_count);
    end

    a_req_order: assert property (@(posedge clk) disable iff (rst)
        order_probe |-> prev_req_addr == exp_first && last_req_addr == exp_second)
    else begin
        errors++;
        $display("FAIL %0t: memory request order wrong", $time);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic port_read(input int p, input logic [AW-1:0] addr, input logic expect_hit);
        int cycles;
        @(negedge clk);
        req_seen     = 1'b1;
        rreq[p]      = 1'b1;
        raddr[p]     = addr;
        exp_addr[p]  = addr;
        hit_probe[p] = expect_hit;
        cycles       = 0;
        @(negedge clk);
        hit_probe[p] = 1'b0;
        while (!rvalid[p] && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!rvalid[p]) begin
            $display("Port %0d got no answer for address %08h", p + 1, addr);
            errors++;
        end
        // Drop the request in its completion cycle so it is not taken again
        rreq[p] = 1'b0;
    endtask

    task automatic run_stream(input int p);
        for (int i = 0; i < STREAM_LEN; i++) begin
            port_read(p, stream[p][i], 1'b0);
        end
    endtask

    // Four tags over eight sets, so two ways see conflict misses
    task automatic make_stream();
        for (int i = 0; i < STREAM_LEN; i++) begin
            for (int p = 0; p < 2; p++) begin
                stream[p][i] = 32'h0001_0000
                    | (($unsigned($random(seed)) % 4) << 12)
                    | (($unsigned($random(seed)) % 8) << 4)
                    | (($unsigned($random(seed)) % 4) << 2);
            end
        end
    endtask

    task automatic check_requests(input int count, input logic check_order,
                                  input logic [AW-1:0] first, input logic [AW-1:0] second);
        @(negedge clk);
        exp_req_count = count;
        exp_first     = first;
        exp_second    = second;
        req_probe     = 1'b1;
        order_probe   = check_order;
        @(negedge clk);
        req_probe     = 1'b0;
        order_probe   = 1'b0;
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("Test %0d %s finished, %0d errors so far", tests, name, errors);
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (rst && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (rst) begin
            $display("Reset was never released");
            errors++;
        end

        repeat (6) @(negedge clk);
        test_done("idle after reset");

        port_read(0, 32'h0000_2048, 1'b0);
        check_requests(1, 1'b1, 32'h0, 32'h0000_2040);
        test_done("port 1 miss");

        port_read(0, 32'h0000_2044, 1'b1);
        check_requests(1, 1'b0, 32'h0, 32'h0);
        test_done("port 1 hit after refill");

        fork
            port_read(0, 32'h0000_5100, 1'b0);
            port_read(1, 32'h0000_6234, 1'b0);
        join
        port_read(1, 32'h0000_6238, 1'b1);
        check_requests(3, 1'b1, 32'h0000_5100, 32'h0000_6230);
        test_done("both ports miss");

        fixed_delay = 3;
        port_read(1, 32'h0000_7308, 1'b0);
        fixed_delay = -1;
        check_requests(4, 1'b1, 32'h0000_6230, 32'h0000_7300);
        test_done("stalled memory request");

        make_stream();
        fork
            run_stream(0);
            run_stream(1);
        join
        test_done("random stream");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/icache_mem_pkg.sv
source/icache_geom_pkg.sv
source/icache_refill_if.sv
source/icache_way_ram.sv
source/icache_lookup.sv
source/icache_refill.sv
source/icache_top.sv
verification/tb_clock.sv
verification/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module icache_tb -f vlog.f \
    && (./obj_dir/Vicache_tb 2>&1 | tee sim.log) \
    || echo "Something failed" >> sim.log

grep -q "Something failed" sim.log && exit 1
exit 0
